// File: tb.f
+incdir+rtl
rtl/mam_pkg.sv
rtl/mam_ifs.sv
rtl/mam_packet_parser.sv
rtl/mam_access_engine.sv
rtl/mam_response_packetizer.sv
rtl/mam_memory.sv
rtl/mam_top.sv
verification/tb_clk_gen.sv
verification/mam_checker.sv
verification/mam_assert.sv
verification/mam_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the MAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module mam_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vmam_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
   exit 0
fi
exit 1

// File: verification/mam_tb.sv
`timescale 1ns/1ps
`include "mam_defines.svh"

module mam_tb;

   localparam logic [9:0] TB_ID = 10'h2a5;

   logic        clk;
   logic        rst;
   logic [9:0]  id;
   logic        debug_in_valid;
   logic [15:0] debug_in_data;
   logic        debug_in_last;
   logic        debug_in_ready;
   logic        debug_out_valid;
   logic [15:0] debug_out_data;
   logic        debug_out_last;
   logic        debug_out_ready = 1'b1;
   logic        bp_mode = 1'b0;  // Random back-pressure on debug_out
   int          mismatch_cnt;
   int          unexpected_cnt;
   int          missing_cnt;
   int          flit_budget = 0;  // Stimulus and response flits so far
   int          cycle_cnt = 0;

   logic [`MAM_DATA_WIDTH-1:0] ref_mem [`MAM_MEM_WORDS];
   logic [15:0]                pkt_q[$];
   logic [16:0]                exp_flits[$];  // {last, data}

   tb_clk_gen clk_gen_i (.clk(clk));

   mam_top dut_i (
      .clk             (clk),
      .rst             (rst),
      .id              (id),
      .debug_in_valid  (debug_in_valid),
      .debug_in_data   (debug_in_data),
      .debug_in_last   (debug_in_last),
      .debug_in_ready  (debug_in_ready),
      .debug_out_valid (debug_out_valid),
      .debug_out_data  (debug_out_data),
      .debug_out_last  (debug_out_last),
      .debug_out_ready (debug_out_ready)
   );

   mam_checker chk_i (
      .clk            (clk),
      .rst            (rst),
      .valid          (debug_out_valid),
      .data           (debug_out_data),
      .last           (debug_out_last),
      .ready          (debug_out_ready),
      .mismatch_cnt   (mismatch_cnt),
      .unexpected_cnt (unexpected_cnt),
      .missing_cnt    (missing_cnt)
   );

   // Byte strobe merge into the model word
   function automatic void apply_write(input int idx, input logic [31:0] data,
                                       input logic [3:0] strb);
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            ref_mem[idx][8*b +: 8] = data[8*b +: 8];
         end
      end
   endfunction

   function automatic void expect_read_flits(input int idx, input int beats);
      int          cnt;
      logic [31:0] word;
      logic [15:0] flit;
      logic        last;
      cnt = 0;
      exp_flits.delete();
      for (int w = 0; w < beats; w++) begin
         word = ref_mem[(idx + w) % `MAM_MEM_WORDS];
         for (int h = 0; h < 2; h++) begin
            if (cnt == 0) begin
               exp_flits.push_back({1'b0, 16'h0000});
               exp_flits.push_back({1'b0, 2'b01, 4'b1111, id});
               cnt = 2;
            end
            flit = (h == 0) ? word[31:16] : word[15:0];  // Upper half first
            cnt++;
            last = (cnt == `MAM_MAX_PKT_LEN) || (h == 1 && w == beats - 1);
            exp_flits.push_back({last, flit});
            if (last) begin
               cnt = 0;
            end
         end
      end
   endfunction

   task automatic send_packet();
      flit_budget += pkt_q.size();
      for (int i = 0; i < pkt_q.size(); i++) begin
         @(negedge clk);
         debug_in_valid = 1'b1;
         debug_in_data  = pkt_q[i];
         debug_in_last  = (i == pkt_q.size() - 1);
         while (!debug_in_ready) begin
            @(negedge clk);
         end
      end
      @(negedge clk);
      debug_in_valid = 1'b0;
      debug_in_last  = 1'b0;
      pkt_q.delete();
   endtask

   task automatic push_header();
      pkt_q.push_back(16'h0000);  // Destination
      pkt_q.push_back(16'h0001);  // Source and type
   endtask

   task automatic push_cmd(input logic [15:0] cmd, input int idx);
      logic [31:0] addr;
      addr = 32'(idx) << 2;
      push_header();
      pkt_q.push_back(cmd);
      pkt_q.push_back(addr[15:0]);
      pkt_q.push_back(addr[31:16]);
   endtask

   task automatic write_single(input int idx, input logic [3:0] strb, input bit split);
      logic [31:0] data;
      data = $urandom();
      push_cmd({1'b1, 1'b0, 10'd0, strb}, idx);
      if (split) begin
         send_packet();  // Data goes in its own packet
         push_header();
      end
      pkt_q.push_back(data[31:16]);
      pkt_q.push_back(data[15:0]);
      send_packet();
      apply_write(idx, data, strb);
   endtask

   task automatic write_burst(input int idx, input int beats, input int per_pkt);
      logic [31:0] data;
      push_cmd({1'b1, 1'b1, 14'(beats)}, idx);
      for (int w = 0; w < beats; w++) begin
         if (w != 0 && w % per_pkt == 0) begin
            send_packet();
            push_header();  // Continuation packet
         end
         data = $urandom();
         pkt_q.push_back(data[31:16]);
         pkt_q.push_back(data[15:0]);
         apply_write(idx + w, data, 4'hf);
      end
      send_packet();
   endtask

   task automatic read_words(input string name, input int idx, input int beats);
      expect_read_flits(idx, beats);
      flit_budget += exp_flits.size();
      foreach (exp_flits[i]) begin
         chk_i.push_expected(name, exp_flits[i]);
      end
      push_cmd((beats == 1) ? 16'h0000 : {2'b01, 14'(beats)}, idx);
      send_packet();
   endtask

   task automatic wait_drain();
      while (chk_i.pending_count() != 0) begin
         @(negedge clk);
      end
   endtask

   always @(negedge clk) begin
      if (bp_mode) begin
         debug_out_ready = (($urandom() % 4) != 0);
      end else begin
         debug_out_ready = 1'b1;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > 40 * flit_budget + 500) begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
         chk_i.report_missing();
         $display("Result: FAILED");
         $finish;
      end
   end

   initial begin
      void'($urandom(76090));
      rst            = 1'b1;
      id             = TB_ID;
      debug_in_valid = 1'b0;
      debug_in_data  = 16'h0000;
      debug_in_last  = 1'b0;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      repeat (8) @(negedge clk);  // Any flit here counts as unexpected

      // Full words, then strobed merges, word 5 with data in its own packet
      write_single(4, 4'hf, 1'b0);
      write_single(5, 4'hf, 1'b0);
      write_single(6, 4'hf, 1'b0);
      write_single(4, 4'b0101, 1'b0);
      write_single(5, 4'b1000, 1'b1);
      write_single(6, 4'b0011, 1'b0);
      read_words("single_strb", 4, 1);
      read_words("single_strb", 5, 1);
      read_words("single_strb", 6, 1);
      wait_drain();

      write_burst(16, 3, 3);
      read_words("burst3", 16, 3);
      wait_drain();
      write_burst(32, 7, 7);
      read_words("burst7_split", 32, 7);
      wait_drain();
      write_burst(48, 5, 2);  // Three debug packets
      read_words("burst5_span", 48, 5);
      wait_drain();

      bp_mode = 1'b1;
      read_words("bp_single", 4, 1);
      read_words("bp_burst3", 16, 3);
      read_words("bp_burst7", 32, 7);
      read_words("bp_burst5", 48, 5);
      wait_drain();
      bp_mode = 1'b0;
      repeat (20) @(negedge clk);

      chk_i.report_missing();
      $display("Errors: %0d mismatched, %0d unexpected, %0d missing flits",
               mismatch_cnt, unexpected_cnt, missing_cnt);
      if (mismatch_cnt + unexpected_cnt + missing_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: verification/mam_assert.sv
`timescale 1ns/1ps

module mam_assert (
   input logic        clk,
   input logic        rst,
   input logic        debug_in_ready,
   input logic        debug_out_valid,
   input logic [15:0] debug_out_data,
   input logic        debug_out_last,
   input logic        debug_out_ready
);

   // A stalled output flit holds until it is taken
   out_stable_a: assert property (@(posedge clk) disable iff (rst)
      debug_out_valid && !debug_out_ready |=>
         debug_out_valid && $stable(debug_out_data) && $stable(debug_out_last))
      else $error("debug_out flit changed before it was accepted");

   out_quiet_a: assert property (@(posedge clk) rst && $past(rst) |-> !debug_out_valid)
      else $error("debug_out_valid was high during reset");

   in_quiet_a: assert property (@(posedge clk) rst && $past(rst) |-> !debug_in_ready)
      else $error("debug_in_ready was high during reset");

endmodule

bind mam_top mam_assert assert_i (
   .clk             (clk),
   .rst             (rst),
   .debug_in_ready  (debug_in_ready),
   .debug_out_valid (debug_out_valid),
   .debug_out_data  (debug_out_data),
   .debug_out_last  (debug_out_last),
   .debug_out_ready (debug_out_ready)
);

// File: verification/mam_checker.sv
`timescale 1ns/1ps

module mam_checker (
   input  logic        clk,
   input  logic        rst,
   input  logic        valid,
   input  logic [15:0] data,
   input  logic        last,
   input  logic        ready,
   output int          mismatch_cnt,
   output int          unexpected_cnt,
   output int          missing_cnt
);

   logic [16:0] exp_q[$];  // {last, data}
   string       name_q[$];  // Test that queued each flit
   logic [16:0] exp_flit;
   string       exp_name;

   task automatic push_expected(input string name, input logic [16:0] flit);
      exp_q.push_back(flit);
      name_q.push_back(name);
   endtask

   function automatic int pending_count();
      return exp_q.size();
   endfunction

   task automatic report_missing();
      missing_cnt = exp_q.size();
      if (missing_cnt != 0) begin
         $display("%0d expected flits never appeared on debug_out, first one from test %s",
                  missing_cnt, name_q[0]);
      end
   endtask

   // Flit is taken on a cycle with valid and ready both high
   always @(posedge clk) begin
      if (!rst && valid && ready) begin
         if (exp_q.size() == 0) begin
            unexpected_cnt++;
            $display("Unexpected flit %h on debug_out while no response was pending", data);
         end else begin
            exp_flit = exp_q.pop_front();
            exp_name = name_q.pop_front();
            if (exp_flit != {last, data}) begin
               mismatch_cnt++;
               $display("Fail %s: expected data %h last %b, actual data %h last %b",
                        exp_name, exp_flit[15:0], exp_flit[16], data, last);
            end
         end
      end
   end

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;  // 4 ns period
      end
   end

endmodule

// File: rtl/mam_top.sv
`timescale 1ns/1ps
`include "mam_defines.svh"

module mam_top import mam_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic [9:0]  id,
   input  logic        debug_in_valid,
   input  logic [15:0] debug_in_data,
   input  logic        debug_in_last,
   output logic        debug_in_ready,
   output logic        debug_out_valid,
   output logic [15:0] debug_out_data,
   output logic        debug_out_last,
   input  logic        debug_out_ready
);

   flit_if    in_flit ();
   flit_if    out_flit ();
   mem_req_if cmd ();
   word_if    wr_word ();   // Parser to engine
   word_if    rd_word ();   // Engine to packetizer

   logic                       req_valid;
   logic                       req_ready;
   mam_cmd_e                   req_rw;
   logic [`MAM_ADDR_WIDTH-1:0] req_addr;
   logic                       req_burst;
   logic [13:0]                req_beats;
   logic                       write_valid;
   logic [`MAM_DATA_WIDTH-1:0] write_data;
   logic [`MAM_STRB_WIDTH-1:0] write_strb;
   logic                       write_ready;
   logic                       read_valid;
   logic [`MAM_DATA_WIDTH-1:0] read_data;
   logic                       read_ready;

   assign in_flit.valid   = debug_in_valid;
   assign in_flit.data    = debug_in_data;
   assign in_flit.last    = debug_in_last;
   assign debug_in_ready  = in_flit.ready;
   assign debug_out_valid = out_flit.valid;
   assign debug_out_data  = out_flit.data;
   assign debug_out_last  = out_flit.last;
   assign out_flit.ready  = debug_out_ready;

   mam_packet_parser parser_i (
      .clk     (clk),
      .rst     (rst),
      .flit_in (in_flit),
      .req     (cmd),
      .wdata   (wr_word)
   );

   mam_access_engine engine_i (
      .clk         (clk),
      .rst         (rst),
      .req         (cmd),
      .wdata       (wr_word),
      .rdata       (rd_word),
      .req_valid   (req_valid),
      .req_rw      (req_rw),
      .req_addr    (req_addr),
      .req_burst   (req_burst),
      .req_beats   (req_beats),
      .req_ready   (req_ready),
      .write_valid (write_valid),
      .write_data  (write_data),
      .write_strb  (write_strb),
      .write_ready (write_ready),
      .read_valid  (read_valid),
      .read_data   (read_data),
      .read_ready  (read_ready)
   );

   mam_response_packetizer packetizer_i (
      .clk      (clk),
      .rst      (rst),
      .id       (id),
      .rdata    (rd_word),
      .flit_out (out_flit)
   );

   mam_memory memory_i (
      .clk         (clk),
      .rst         (rst),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req_rw      (req_rw),
      .req_addr    (req_addr),
      .req_burst   (req_burst),
      .req_beats   (req_beats),
      .write_valid (write_valid),
      .write_data  (write_data),
      .write_strb  (write_strb),
      .write_ready (write_ready),
      .read_valid  (read_valid),
      .read_data   (read_data),
      .read_ready  (read_ready)
   );

endmodule

// File: rtl/mam_memory.sv
`timescale 1ns/1ps
`include "mam_defines.svh"

module mam_memory import mam_pkg::*; (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       req_valid,
   output logic                       req_ready,
   input  mam_cmd_e                   req_rw,
   input  logic [`MAM_ADDR_WIDTH-1:0] req_addr,
   input  logic                       req_burst,
   input  logic [13:0]                req_beats,
   input  logic                       write_valid,
   input  logic [`MAM_DATA_WIDTH-1:0] write_data,
   input  logic [`MAM_STRB_WIDTH-1:0] write_strb,
   output logic                       write_ready,
   output logic                       read_valid,
   output logic [`MAM_DATA_WIDTH-1:0] read_data,
   input  logic                       read_ready
);

   localparam int IDX_W = $clog2(`MAM_MEM_WORDS);

   logic [`MAM_DATA_WIDTH-1:0] mem [`MAM_MEM_WORDS];
   logic                       busy;
   mam_cmd_e                   mode;
   logic [IDX_W-1:0]           idx;       // Burst word address
   logic [IDX_W-1:0]           req_idx;
   logic [IDX_W-1:0]           next_idx;
   logic [13:0]                beats_left;

   assign req_idx     = req_addr[IDX_W+1:2];  // Byte address to word index
   assign next_idx    = idx + 1'b1;
   assign req_ready   = !busy;
   assign write_ready = busy && (mode == MAM_WRITE);

   always_ff @(posedge clk) begin
      if (rst) begin
         busy       <= 1'b0;
         read_valid <= 1'b0;
      end else if (req_valid && req_ready) begin
         busy       <= 1'b1;
         mode       <= req_rw;
         idx        <= req_idx;
         beats_left <= req_burst ? req_beats : 14'd1;
         read_valid <= (req_rw == MAM_READ);
      end else if ((write_valid && write_ready) || (read_valid && read_ready)) begin
         idx        <= next_idx;
         beats_left <= beats_left - 14'd1;
         if (beats_left == 14'd1) begin
            busy       <= 1'b0;
            read_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         read_data <= mem[req_idx];
      end else if (read_valid && read_ready) begin
         read_data <= mem[next_idx];  // Prefetch the next beat
      end
      if (write_valid && write_ready) begin
         for (int b = 0; b < `MAM_STRB_WIDTH; b++) begin
            if (write_strb[b]) begin
               mem[idx][8*b +: 8] <= write_data[8*b +: 8];
            end
         end
      end
   end

endmodule

// File: rtl/mam_response_packetizer.sv
`timescale 1ns/1ps
`include "mam_defines.svh"

module mam_response_packetizer import mam_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic [9:0] id,
   word_if.sink       rdata,
   flit_if.source     flit_out
);

   localparam int CNT_W = $clog2(`MAM_MAX_PKT_LEN + 1);

   mam_pkt_state_e   state;
   logic [CNT_W-1:0] flit_cnt;  // Flits loaded into the current packet
   logic             half;      // Lower half of the word next
   logic             out_valid;
   logic [15:0]      out_data;
   logic             out_last;
   logic             slot_free;
   logic             pkt_full;
   logic             data_last;
   logic [15:0]      data_flit;

   assign flit_out.valid = out_valid;
   assign flit_out.data  = out_data;
   assign flit_out.last  = out_last;

   assign slot_free = !out_valid || flit_out.ready;
   assign pkt_full  = (flit_cnt == CNT_W'(`MAM_MAX_PKT_LEN - 1));
   assign data_last = pkt_full || (half && rdata.last);
   assign data_flit = half ? rdata.data[15:0] : rdata.data[`MAM_DATA_WIDTH-1 -: 16];

   // Word is popped with its lower flit
   assign rdata.ready = (state == K_DATA) && half && slot_free;

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= K_HDR0;
         out_valid <= 1'b0;
         half      <= 1'b0;
         flit_cnt  <= '0;
      end else begin
         if (flit_out.ready) begin
            out_valid <= 1'b0;
         end
         case (state)
            K_HDR0: begin
               if (rdata.valid && slot_free) begin
                  out_valid <= 1'b1;
                  out_data  <= 16'h0000;
                  out_last  <= 1'b0;
                  flit_cnt  <= CNT_W'(1);
                  state     <= K_HDR1;
               end
            end
            K_HDR1: begin
               if (slot_free) begin
                  out_valid <= 1'b1;
                  out_data  <= {2'b01, 4'b1111, id};
                  out_last  <= 1'b0;
                  flit_cnt  <= CNT_W'(2);
                  state     <= K_DATA;
               end
            end
            K_DATA: begin
               if (rdata.valid && slot_free) begin
                  out_valid <= 1'b1;
                  out_data  <= data_flit;
                  out_last  <= data_last;
                  flit_cnt  <= flit_cnt + 1'b1;
                  half      <= !half;
                  if (data_last) begin
                     state <= K_HDR0;  // Next packet waits for data
                  end
               end
            end
            default: state <= K_HDR0;
         endcase
      end
   end

endmodule

// File: rtl/mam_access_engine.sv
`timescale 1ns/1ps
`include "mam_defines.svh"

module mam_access_engine import mam_pkg::*; (
   input  logic                       clk,
   input  logic                       rst,
   mem_req_if.sink                    req,
   word_if.sink                       wdata,
   word_if.source                     rdata,
   output logic                       req_valid,
   output mam_cmd_e                   req_rw,
   output logic [`MAM_ADDR_WIDTH-1:0] req_addr,
   output logic                       req_burst,
   output logic [13:0]                req_beats,
   input  logic                       req_ready,
   output logic                       write_valid,
   output logic [`MAM_DATA_WIDTH-1:0] write_data,
   output logic [`MAM_STRB_WIDTH-1:0] write_strb,
   input  logic                       write_ready,
   input  logic                       read_valid,
   input  logic [`MAM_DATA_WIDTH-1:0] read_data,
   output logic                       read_ready
);

   mam_engine_state_e          state;
   logic [13:0]                beat_cnt;  // Beats still to transfer
   logic [`MAM_STRB_WIDTH-1:0] strb_reg;

   assign req.ready   = (state == E_IDLE);
   assign req_valid   = (state == E_REQ);
   assign write_valid = (state == E_WRITE) && wdata.valid;
   assign write_data  = wdata.data;
   assign write_strb  = req_burst ? '1 : strb_reg;  // Bursts write whole words
   assign wdata.ready = (state == E_WRITE) && write_ready;
   assign rdata.valid = (state == E_READ) && read_valid;
   assign rdata.data  = read_data;
   assign rdata.last  = (beat_cnt == 14'd1);
   assign read_ready  = (state == E_READ) && rdata.ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= E_IDLE;
      end else begin
         case (state)
            E_IDLE: begin
               if (req.valid) begin
                  req_rw    <= req.rw;
                  req_addr  <= req.addr;
                  req_burst <= req.burst;
                  req_beats <= req.beats;
                  strb_reg  <= req.strb;
                  beat_cnt  <= req.beats;
                  state     <= E_REQ;
               end
            end
            E_REQ: begin
               if (req_ready) begin
                  state <= (req_rw == MAM_WRITE) ? E_WRITE : E_READ;
               end
            end
            E_WRITE: begin
               if (write_valid && write_ready) begin
                  beat_cnt <= beat_cnt - 14'd1;
                  if (beat_cnt == 14'd1) begin
                     state <= E_IDLE;
                  end
               end
            end
            E_READ: begin
               if (read_valid && read_ready) begin
                  beat_cnt <= beat_cnt - 14'd1;
                  if (beat_cnt == 14'd1) begin
                     state <= E_IDLE;
                  end
               end
            end
            default: state <= E_IDLE;
         endcase
      end
   end

endmodule

// File: rtl/mam_packet_parser.sv
`timescale 1ns/1ps
`include "mam_defines.svh"

module mam_packet_parser import mam_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   flit_if.receiver  flit_in,
   mem_req_if.source req,
   word_if.source    wdata
);

   mam_parse_state_e           state;
   logic                       armed;         // Held low through reset
   logic                       addr_half;     // Second address flit next
   logic                       hdr_cnt;       // Second header flit next
   logic                       data_half;     // Lower half of word next
   logic                       is_last_flit;  // Packet ended at the address
   logic [13:0]                beats_left;
   logic [`MAM_DATA_WIDTH-1:0] word_reg;
   logic                       word_valid;
   logic                       flit_ok;

   assign flit_ok     = flit_in.valid && flit_in.ready;
   assign req.valid   = (state == P_ISSUE);
   assign wdata.valid = word_valid;
   assign wdata.data  = word_reg;
   assign wdata.last  = 1'b0;

   always_comb begin
      case (state)
         P_ISSUE: flit_in.ready = 1'b0;
         P_DATA:  flit_in.ready = armed && !word_valid;  // One word in flight
         default: flit_in.ready = armed;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= P_IDLE;
         armed      <= 1'b0;
         word_valid <= 1'b0;
      end else begin
         armed <= 1'b1;
         if (word_valid && wdata.ready) begin
            word_valid <= 1'b0;
         end
         case (state)
            P_IDLE: begin
               if (flit_ok) begin
                  state <= P_SRC;
               end
            end
            P_SRC: begin
               if (flit_ok) begin
                  state <= P_CMD;
               end
            end
            P_CMD: begin
               if (flit_ok) begin
                  req.rw    <= mam_cmd_e'(flit_in.data[15]);
                  req.burst <= flit_in.data[14];
                  req.strb  <= flit_in.data[`MAM_STRB_WIDTH-1:0];
                  if (flit_in.data[14]) begin
                     req.beats  <= flit_in.data[13:0];
                     beats_left <= flit_in.data[13:0];
                  end else begin
                     req.beats  <= 14'd1;  // Single access
                     beats_left <= 14'd1;
                  end
                  addr_half <= 1'b0;
                  state     <= P_ADDR;
               end
            end
            P_ADDR: begin
               if (flit_ok) begin
                  req.addr[addr_half*16 +: 16] <= flit_in.data;  // Low half first
                  addr_half <= 1'b1;
                  if (addr_half) begin
                     is_last_flit <= flit_in.last;
                     state        <= P_ISSUE;
                  end
               end
            end
            P_ISSUE: begin
               if (req.ready) begin
                  data_half <= 1'b0;
                  hdr_cnt   <= 1'b0;
                  if (req.rw == MAM_READ) begin
                     state <= P_IDLE;
                  end else if (is_last_flit) begin
                     state <= P_HDR;  // Data starts in the next packet
                  end else begin
                     state <= P_DATA;
                  end
               end
            end
            P_HDR: begin
               if (flit_ok) begin
                  hdr_cnt <= 1'b1;
                  if (hdr_cnt) begin
                     state <= P_DATA;
                  end
               end
            end
            P_DATA: begin
               if (flit_ok) begin
                  data_half <= !data_half;
                  if (!data_half) begin
                     word_reg[`MAM_DATA_WIDTH-1 -: 16] <= flit_in.data;
                  end else begin
                     word_reg[15:0] <= flit_in.data;
                     word_valid     <= 1'b1;
                     beats_left     <= beats_left - 14'd1;
                  end
                  if (data_half && beats_left == 14'd1) begin
                     state <= P_IDLE;
                  end else if (flit_in.last) begin
                     hdr_cnt <= 1'b0;  // Burst goes on in a continuation packet
                     state   <= P_HDR;
                  end
               end
            end
            default: state <= P_IDLE;
         endcase
      end
   end

endmodule

// File: rtl/mam_ifs.sv
`timescale 1ns/1ps
`include "mam_defines.svh"

interface flit_if;
   logic        valid;
   logic [15:0] data;
   logic        last;
   logic        ready;

   modport source (output valid, data, last, input ready);
   modport receiver (input valid, data, last, output ready);
endinterface

interface word_if;
   logic                       valid;
   logic [`MAM_DATA_WIDTH-1:0] data;
   logic                       last;  // Final read beat
   logic                       ready;

   modport source (output valid, data, last, input ready);
   modport sink (input valid, data, last, output ready);
endinterface

interface mem_req_if import mam_pkg::*; ();
   logic                       valid;
   logic                       ready;
   mam_cmd_e                   rw;
   logic [`MAM_ADDR_WIDTH-1:0] addr;
   logic                       burst;
   logic [13:0]                beats;
   logic [`MAM_STRB_WIDTH-1:0] strb;  // Single writes only

   modport source (output valid, rw, addr, burst, beats, strb, input ready);
   modport sink (input valid, rw, addr, burst, beats, strb, output ready);
endinterface

// File: rtl/mam_pkg.sv
package mam_pkg;

   typedef enum logic {
      MAM_READ  = 1'b0,
      MAM_WRITE = 1'b1
   } mam_cmd_e;  // Command flit bit 15

   typedef enum logic [2:0] {
      P_IDLE,    // Destination flit
      P_SRC,     // Source and type flit
      P_CMD,
      P_ADDR,
      P_ISSUE,   // Request waits on the engine
      P_HDR,     // Continuation packet header
      P_DATA
   } mam_parse_state_e;

   typedef enum logic [1:0] {
      E_IDLE, E_REQ, E_WRITE, E_READ
   } mam_engine_state_e;

   typedef enum logic [1:0] {
      K_HDR0, K_HDR1, K_DATA
   } mam_pkt_state_e;

endpackage

// File: rtl/mam_defines.svh
`ifndef MAM_DEFINES_SVH
`define MAM_DEFINES_SVH

// Memory word width in bits, two flits per word
`define MAM_DATA_WIDTH 32

// Request address width, sent as two flits low half first
`define MAM_ADDR_WIDTH 32

`define MAM_STRB_WIDTH (`MAM_DATA_WIDTH / 8)

// Flits per response packet including both header flits
`define MAM_MAX_PKT_LEN 8

`define MAM_MEM_WORDS 256

`endif
